/* hbm_wr_consts.svh */
// sizing constants for the HBM write path
// include wherever a width, depth or limit is needed; the package pulls it in too
`ifndef HBM_WR_CONSTS_SVH
`define HBM_WR_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// AXI widths
//////////////////////////////////////////////////////////////////////

// byte address width of the AXI master
`define HBM_ADDR_W 64
// one beat of write data
`define HBM_DATA_W 512
// bytes per beat, also the address step between updates
`define HBM_BEAT_BYTES 64

//////////////////////////////////////////////////////////////////////
// staging and flow control
//////////////////////////////////////////////////////////////////////

// entries in each staging FIFO
`define HBM_FIFO_DEPTH 32
// occupancy at which stage_full goes high
`define HBM_PROG_FULL 16
// AW transfers allowed in flight without a B response
`define HBM_MAX_OUTSTANDING 32

`endif

/* hbm_wr_pkg.sv */
// shared types of the HBM write path
// modules import this inside their body, ports use scoped names
`include "hbm_wr_consts.svh"

package hbm_wr_pkg;

  //////////////////////////////////////////////////////////////////////
  // scalar types
  //////////////////////////////////////////////////////////////////////

  // AXI byte address
  typedef logic [`HBM_ADDR_W-1:0] hbm_addr_t;

  // one full write beat
  typedef logic [`HBM_DATA_W-1:0] hbm_data_t;

  //////////////////////////////////////////////////////////////////////
  // channel payloads
  //////////////////////////////////////////////////////////////////////

  // AW payload, single beat so len is always zero
  typedef struct packed {
    hbm_addr_t  address;
    logic [7:0] len;
  } hbm_aw_chan_t;

  // W payload, one strobe bit per data byte
  typedef struct packed {
    hbm_data_t                 data;
    logic [`HBM_DATA_W/8-1:0] strb;
    logic                      last;
  } hbm_w_chan_t;

  //////////////////////////////////////////////////////////////////////
  // FSM states
  //////////////////////////////////////////////////////////////////////

  // ingress is armed by a start pulse
  typedef enum logic {ing_idle, ing_running} hbm_ingress_state_t;

  // AW launcher, one address in flight on the bus at a time
  typedef enum logic {aw_idle, aw_valid} hbm_aw_state_t;

endpackage

/* hbm_stage_fifo.sv */
// synchronous first-word-fall-through FIFO used to stage AW addresses and W beats
// head_data is valid whenever not_empty is high; prog_full warns the producer early
`timescale 1ns/1ps
`include "hbm_wr_consts.svh"

module hbm_stage_fifo #(
  parameter int WIDTH = 64
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] head_data,
  output logic             not_empty,
  output logic             prog_full
);

  //////////////////////////////////////////////////////////////////////
  // sizing
  //////////////////////////////////////////////////////////////////////

  localparam int DEPTH = `HBM_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  // count needs one more state than pointers to tell full from empty
  localparam int CNT_W = $clog2(DEPTH + 1);

  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(DEPTH);
  localparam logic [CNT_W-1:0] PFULL_CNT = CNT_W'(`HBM_PROG_FULL);

  // storage, payload only
  logic [WIDTH-1:0] mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic full;
  logic wr_en;
  logic rd_en;

  //////////////////////////////////////////////////////////////////////
  // qualified strobes
  //////////////////////////////////////////////////////////////////////

  assign full      = (count == FULL_CNT);
  assign not_empty = (count != '0);

  // push into a full FIFO is dropped
  assign wr_en = push && !full;
  // pop of an empty FIFO does nothing
  assign rd_en = pop && not_empty;

  //////////////////////////////////////////////////////////////////////
  // storage write
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // head falls through without a read cycle
  assign head_data = mem[rd_ptr];

  //////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count as is
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // threshold flag, inclusive
  assign prog_full = (count >= PFULL_CNT);

endmodule

/* hbm_update_ingress.sv */
// accepts producer updates and turns each into an address entry and a data entry
// a start pulse captures the beat-aligned base and arms the path; updates while idle are dropped
`timescale 1ns/1ps
`include "hbm_wr_consts.svh"

module hbm_update_ingress (
  input  logic                  aclk,
  input  logic                  areset,
  input  logic                  start,
  input  hbm_wr_pkg::hbm_addr_t base_addr,
  input  logic                  update_valid,
  input  hbm_wr_pkg::hbm_data_t update_data,
  output logic                  push,
  output hbm_wr_pkg::hbm_addr_t push_addr,
  output hbm_wr_pkg::hbm_data_t push_data
);

  import hbm_wr_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // address arithmetic
  //////////////////////////////////////////////////////////////////////

  // log2 of the per-update address step
  localparam int BEAT_SHIFT = $clog2(`HBM_BEAT_BYTES);
  // index covers every beat of the address space
  localparam int IDX_W      = `HBM_ADDR_W - BEAT_SHIFT;

  // low bits cleared on capture
  localparam hbm_addr_t BEAT_MASK = hbm_addr_t'(`HBM_BEAT_BYTES - 1);

  hbm_ingress_state_t state;

  // aligned base, loaded on start
  hbm_addr_t        base_r;
  // number of updates accepted since the last start
  logic [IDX_W-1:0] upd_idx;

  logic accept;

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  // start arms the path on the following edge; only reset disarms it
  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= ing_idle;
    end else if (start) begin
      state <= ing_running;
    end
  end

  always_ff @(posedge aclk) begin
    if (start) begin
      base_r <= base_addr & ~BEAT_MASK;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // update numbering
  //////////////////////////////////////////////////////////////////////

  assign accept = update_valid && (state == ing_running);

  // a start while running restarts numbering at zero,
  // an update on that same edge still goes out under the old base
  always_ff @(posedge aclk) begin
    if (areset) begin
      upd_idx <= '0;
    end else if (start) begin
      upd_idx <= '0;
    end else if (accept) begin
      upd_idx <= upd_idx + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // FIFO entries
  //////////////////////////////////////////////////////////////////////

  // both FIFOs are written on the accepting edge
  assign push      = accept;
  // base + index * beat bytes, done as a shift
  assign push_addr = base_r + {upd_idx, {BEAT_SHIFT{1'b0}}};
  assign push_data = update_data;

endmodule

/* hbm_write_issuer.sv */
// AXI4 write master side of the path; AW, W and B channels run independently
// AW launches from the address FIFO head under a credit limit, W streams the data FIFO head
`timescale 1ns/1ps
`include "hbm_wr_consts.svh"

module hbm_write_issuer (
  input  logic                     aclk,
  input  logic                     areset,
  // staging FIFO heads
  input  hbm_wr_pkg::hbm_addr_t    aw_head,
  input  logic                     aw_not_empty,
  input  hbm_wr_pkg::hbm_data_t    w_head,
  input  logic                     w_not_empty,
  output logic                     aw_pop,
  output logic                     w_pop,
  // AXI AW
  output logic                     awvalid,
  input  logic                     awready,
  output hbm_wr_pkg::hbm_aw_chan_t aw,
  // AXI W
  output logic                     wvalid,
  input  logic                     wready,
  output hbm_wr_pkg::hbm_w_chan_t  w,
  // AXI B
  input  logic                     bvalid,
  output logic                     bready
);

  import hbm_wr_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // credit sizing
  //////////////////////////////////////////////////////////////////////

  localparam int CRED_W = $clog2(`HBM_MAX_OUTSTANDING + 1);

  localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`HBM_MAX_OUTSTANDING);

  hbm_aw_state_t aw_state;

  // free slots for AW transfers awaiting B
  logic [CRED_W-1:0] credit;
  logic              credit_zero;

  logic aw_xfer;
  logic w_xfer;
  logic b_xfer;

  //////////////////////////////////////////////////////////////////////
  // AW channel
  //////////////////////////////////////////////////////////////////////

  assign credit_zero = (credit == '0);
  assign aw_xfer     = awvalid && awready;

  // valid goes up the edge after an address is waiting and credit remains,
  // drops on the transfer edge, so at most one AW per two cycles
  always_ff @(posedge aclk) begin
    if (areset) begin
      aw_state <= aw_idle;
    end else begin
      case (aw_state)
        aw_idle: begin
          if (aw_not_empty && !credit_zero) begin
            aw_state <= aw_valid;
          end
        end
        aw_valid: begin
          if (awready) begin
            aw_state <= aw_idle;
          end
        end
        default: aw_state <= aw_idle;
      endcase
    end
  end

  assign awvalid = (aw_state == aw_valid);

  // head stays put until the pop, which keeps the payload stable under valid
  assign aw.address = aw_head;
  assign aw.len     = 8'd0;

  assign aw_pop = aw_xfer;

  //////////////////////////////////////////////////////////////////////
  // W channel
  //////////////////////////////////////////////////////////////////////

  // no register here, valid follows the FIFO directly
  assign wvalid = w_not_empty;
  assign w_xfer = wvalid && wready;

  assign w.data = w_head;
  // full beat, single-beat bursts
  assign w.strb = '1;
  assign w.last = 1'b1;

  assign w_pop = w_xfer;

  //////////////////////////////////////////////////////////////////////
  // B channel and credit
  //////////////////////////////////////////////////////////////////////

  // responses are always taken
  assign bready = 1'b1;
  assign b_xfer = bvalid && bready;

  always_ff @(posedge aclk) begin
    if (areset) begin
      credit <= CRED_MAX;
    end else begin
      case ({aw_xfer, b_xfer})
        2'b10: credit <= credit - 1'b1;
        // a stray B beyond the limit is not counted
        2'b01: begin
          if (credit != CRED_MAX) begin
            credit <= credit + 1'b1;
          end
        end
        default: credit <= credit;
      endcase
    end
  end

endmodule

/* hbm_wr_top.sv */
// top of the HBM write path, producer updates in and AXI4 writes out
// ingress feeds two staging FIFOs; the issuer drains them onto AW and W
`timescale 1ns/1ps
`include "hbm_wr_consts.svh"

module hbm_wr_top (
  input  logic                     aclk,
  input  logic                     areset,
  // control
  input  logic                     start,
  input  hbm_wr_pkg::hbm_addr_t    base_addr,
  // producer
  input  logic                     update_valid,
  input  hbm_wr_pkg::hbm_data_t    update_data,
  output logic                     stage_full,
  // AXI AW
  output logic                     awvalid,
  input  logic                     awready,
  output hbm_wr_pkg::hbm_aw_chan_t aw,
  // AXI W
  output logic                     wvalid,
  input  logic                     wready,
  output hbm_wr_pkg::hbm_w_chan_t  w,
  // AXI B
  input  logic                     bvalid,
  output logic                     bready
);

  import hbm_wr_pkg::*;

  // ingress to FIFOs
  logic      push;
  hbm_addr_t push_addr;
  hbm_data_t push_data;

  // FIFOs to issuer
  hbm_addr_t aw_head;
  logic      aw_not_empty;
  logic      aw_pop;
  hbm_data_t w_head;
  logic      w_not_empty;
  logic      w_pop;

  //////////////////////////////////////////////////////////////////////
  // ingress
  //////////////////////////////////////////////////////////////////////

  hbm_update_ingress u_ingress (
    .aclk         (aclk),
    .areset       (areset),
    .start        (start),
    .base_addr    (base_addr),
    .update_valid (update_valid),
    .update_data  (update_data),
    .push         (push),
    .push_addr    (push_addr),
    .push_data    (push_data)
  );

  //////////////////////////////////////////////////////////////////////
  // staging
  //////////////////////////////////////////////////////////////////////

  // address side fill level tracks the data side, only data drives stage_full
  hbm_stage_fifo #(.WIDTH(`HBM_ADDR_W)) u_addr_fifo (
    .aclk      (aclk),
    .areset    (areset),
    .push      (push),
    .push_data (push_addr),
    .pop       (aw_pop),
    .head_data (aw_head),
    .not_empty (aw_not_empty),
    .prog_full ()
  );

  hbm_stage_fifo #(.WIDTH(`HBM_DATA_W)) u_data_fifo (
    .aclk      (aclk),
    .areset    (areset),
    .push      (push),
    .push_data (push_data),
    .pop       (w_pop),
    .head_data (w_head),
    .not_empty (w_not_empty),
    .prog_full (stage_full)
  );

  //////////////////////////////////////////////////////////////////////
  // AXI issue
  //////////////////////////////////////////////////////////////////////

  hbm_write_issuer u_issuer (
    .aclk         (aclk),
    .areset       (areset),
    .aw_head      (aw_head),
    .aw_not_empty (aw_not_empty),
    .w_head       (w_head),
    .w_not_empty  (w_not_empty),
    .aw_pop       (aw_pop),
    .w_pop        (w_pop),
    .awvalid      (awvalid),
    .awready      (awready),
    .aw           (aw),
    .wvalid       (wvalid),
    .wready       (wready),
    .w            (w),
    .bvalid       (bvalid),
    .bready       (bready)
  );

endmodule

/* hbm_wr_props.sv */
// AXI protocol checks on the top-level ports of the HBM write path
// attached to every hbm_wr_top instance by the bind at the bottom
`timescale 1ns/1ps

module hbm_wr_props (
  input logic                     aclk,
  input logic                     areset,
  input logic                     awvalid,
  input logic                     awready,
  input hbm_wr_pkg::hbm_aw_chan_t aw,
  input logic                     wvalid,
  input logic                     wready,
  input hbm_wr_pkg::hbm_w_chan_t  w
);

  // a pending AW holds valid and payload until the slave takes it
  aw_hold: assert property (@(posedge aclk) disable iff (areset)
    awvalid && !awready |=> awvalid && $stable(aw))
    else $error("awvalid or aw changed before awready");

  // same for the W beat
  w_hold: assert property (@(posedge aclk) disable iff (areset)
    wvalid && !wready |=> wvalid && $stable(w))
    else $error("wvalid or w changed before wready");

  // first edge out of reset sees both channels quiet
  reset_quiet: assert property (@(posedge aclk)
    $fell(areset) |-> !awvalid && !wvalid)
    else $error("awvalid or wvalid high on the cycle after reset");

endmodule

bind hbm_wr_top hbm_wr_props u_props (
  .aclk    (aclk),
  .areset  (areset),
  .awvalid (awvalid),
  .awready (awready),
  .aw      (aw),
  .wvalid  (wvalid),
  .wready  (wready),
  .w       (w)
);

/* tb_hbm_wr_top.sv */
// testbench for the HBM write path
// drives updates into hbm_wr_top, models a random AXI slave and checks every AW and W beat
`timescale 1ns/1ps
`include "hbm_wr_consts.svh"

module tb_hbm_wr_top;

  import hbm_wr_pkg::*;

  // cycles any single wait may take
  localparam int WAIT_LIMIT = 2000;

  logic         aclk;
  logic         areset;
  logic         start;
  hbm_addr_t    base_addr;
  logic         update_valid;
  hbm_data_t    update_data;
  logic         stage_full;
  logic         awvalid;
  logic         awready;
  hbm_aw_chan_t aw;
  logic         wvalid;
  logic         wready;
  hbm_w_chan_t  w;
  logic         bvalid;
  logic         bready;

  // expected traffic is queued when an update is driven
  hbm_addr_t exp_addr_q[$];
  hbm_data_t exp_data_q[$];

  // transfers seen by the checker
  int unsigned aw_seen;
  int unsigned b_seen;
  int unsigned errors;
  int unsigned checks;
  int unsigned tests;

  logic [31:0] rng;
  bit          hold_ready;
  bit          hold_b;

  // producer view of the current run
  hbm_addr_t   cur_base;
  int unsigned cur_idx;
  int unsigned tag;

  hbm_wr_top u_dut (.*);

  always #2 aclk = ~aclk;

  ////////////////////////////////////////////////////////////////////
  // reference model and helpers
  ////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // n-th address after a start is the base rounded down to a beat plus one beat per update
  function automatic hbm_addr_t ref_addr(input hbm_addr_t base, input int unsigned idx);
    hbm_addr_t aligned;
    aligned = base - (base % `HBM_BEAT_BYTES);
    return aligned + hbm_addr_t'(idx) * `HBM_BEAT_BYTES;
  endfunction

  // distinct payload per tag with every 32-bit word different
  function automatic hbm_data_t make_data(input int unsigned t);
    hbm_data_t   d;
    logic [31:0] s;
    s = t;
    for (int i = 0; i < `HBM_DATA_W / 32; i++) begin
      s = lcg_next(s ^ 32'h5a5a0000);
      d[i*32 +: 32] = s;
    end
    return d;
  endfunction

  task automatic report_mismatch(input string sig, input logic [511:0] got,
                                 input logic [511:0] exp);
    $display("Fail time=%0t %s got=%0h exp=%0h", $time, sig, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic end_test(input int num, input string name, input int unsigned err0);
    tests++;
    $display("test %0d %s: %s (%0d errors)", num, name,
             (errors == err0) ? "ok" : "failed", errors - err0);
  endtask

  ////////////////////////////////////////////////////////////////////
  // AXI slave model
  ////////////////////////////////////////////////////////////////////

  // ready about 3/4 of the time and one B per recorded AW
  always begin
    @(posedge aclk);
    #1;
    rng     = lcg_next(rng);
    awready = !hold_ready && (rng[31:30] != 2'b00);
    wready  = !hold_ready && (rng[29:28] != 2'b00);
    bvalid  = !hold_b && (aw_seen != b_seen) && rng[27];
  end

  ////////////////////////////////////////////////////////////////////
  // checker samples mid-cycle ahead of the transfer edge
  ////////////////////////////////////////////////////////////////////

  always @(negedge aclk) begin
    hbm_addr_t ea;
    hbm_data_t ed;
    if (!areset) begin
      if (awvalid && awready) begin
        aw_seen++;
        if (exp_addr_q.size() == 0) begin
          report_problem("AW transfer with no update outstanding");
        end else begin
          ea = exp_addr_q.pop_front();
          assert (aw.address == ea) checks++;
          else report_mismatch("aw.address", aw.address, ea);
        end
        assert (aw.len == 8'd0) checks++;
        else report_mismatch("aw.len", aw.len, 0);
      end
      if (wvalid && wready) begin
        if (exp_data_q.size() == 0) begin
          report_problem("W transfer with no update outstanding");
        end else begin
          ed = exp_data_q.pop_front();
          assert (w.data == ed) checks++;
          else report_mismatch("w.data", w.data, ed);
        end
        assert (&w.strb && w.last) checks++;
        else report_mismatch("w.strb,w.last", {w.strb, w.last},
                             {(`HBM_DATA_W/8+1){1'b1}});
      end
      // a B transfer needs bready too, which must be held high
      if (bvalid) begin
        assert (bready) checks++;
        else report_mismatch("bready", bready, 1'b1);
        if (bready) begin
          b_seen++;
        end
      end
      assert ((aw_seen - b_seen) <= `HBM_MAX_OUTSTANDING) checks++;
      else report_mismatch("outstanding", aw_seen - b_seen, `HBM_MAX_OUTSTANDING);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // stimulus tasks all return 1 ns after a rising edge
  ////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    areset = 1'b1;
    repeat (10) @(posedge aclk);
    #1;
    areset = 1'b0;
  endtask

  task automatic set_holds(input bit ready_off, input bit b_off);
    @(negedge aclk);
    hold_ready = ready_off;
    hold_b     = b_off;
    @(posedge aclk);
    #1;
  endtask

  task automatic do_start(input hbm_addr_t base);
    start     = 1'b1;
    base_addr = base;
    @(posedge aclk);
    #1;
    start    = 1'b0;
    cur_base = base;
    cur_idx  = 0;
  endtask

  // one update for one cycle; accepted says whether the DUT is running
  task automatic send_update(input bit accepted);
    int unsigned waited;
    hbm_data_t   d;
    waited = 0;
    while (stage_full && waited < WAIT_LIMIT) begin
      @(posedge aclk);
      #1;
      waited++;
    end
    assert (!stage_full) else report_problem("stage_full stuck high before an update");
    d = make_data(tag);
    tag++;
    update_valid = 1'b1;
    update_data  = d;
    if (accepted) begin
      exp_addr_q.push_back(ref_addr(cur_base, cur_idx));
      exp_data_q.push_back(d);
      cur_idx++;
    end
    @(posedge aclk);
    #1;
    update_valid = 1'b0;
  endtask

  // wait for every expected beat and every B response
  task automatic drain();
    int unsigned waited;
    waited = 0;
    while ((exp_addr_q.size() != 0 || exp_data_q.size() != 0 || aw_seen != b_seen)
           && waited < WAIT_LIMIT) begin
      @(posedge aclk);
      #1;
      waited++;
    end
    assert (exp_addr_q.size() == 0 && exp_data_q.size() == 0 && aw_seen == b_seen) checks++;
    else report_problem("timed out waiting for AXI traffic to drain");
  endtask

  // no AXI valid may appear for n cycles
  task automatic idle_check(input int n);
    repeat (n) begin
      @(negedge aclk);
      assert (!awvalid && !wvalid) checks++;
      else report_problem("AXI valid raised while the path is idle");
    end
    @(posedge aclk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned err0;
    int unsigned waited;
    aclk         = 1'b0;
    areset       = 1'b1;
    start        = 1'b0;
    base_addr    = '0;
    update_valid = 1'b0;
    update_data  = '0;
    awready      = 1'b0;
    wready       = 1'b0;
    bvalid       = 1'b0;
    rng          = 32'd95644;
    hold_ready   = 1'b0;
    hold_b       = 1'b0;
    aw_seen      = 0;
    b_seen       = 0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    tag          = 1;
    cur_base     = '0;
    cur_idx      = 0;
    apply_reset();

    // unaligned base with addresses stepping by one beat
    err0 = errors;
    do_start(64'h0000_0012_3456_7a5b);
    repeat (24) send_update(1'b1);
    drain();
    end_test(1, "address sequence", err0);

    // bursts with gaps while order and fixed fields are checked per beat
    err0 = errors;
    for (int i = 0; i < 30; i++) begin
      send_update(1'b1);
      if (i % 4 == 3) begin
        @(posedge aclk);
        #1;
      end
    end
    drain();
    end_test(2, "data order and fixed fields", err0);

    // back to idle through reset and then two starts in a row
    err0 = errors;
    apply_reset();
    repeat (5) send_update(1'b0);
    idle_check(12);
    do_start(64'h0000_0040_0000_0107);
    repeat (8) send_update(1'b1);
    do_start(64'h0000_0080_0000_03ff);
    repeat (8) send_update(1'b1);
    drain();
    end_test(3, "idle discard and restart", err0);

    // with both channels stalled the flag tracks the data FIFO level
    err0 = errors;
    set_holds(1'b1, 1'b0);
    for (int k = 1; k <= `HBM_PROG_FULL; k++) begin
      send_update(1'b1);
      assert (stage_full == (k >= `HBM_PROG_FULL)) checks++;
      else report_mismatch("stage_full", stage_full, k >= `HBM_PROG_FULL);
    end
    set_holds(1'b0, 1'b0);
    waited = 0;
    while (stage_full && waited < WAIT_LIMIT) begin
      @(posedge aclk);
      #1;
      waited++;
    end
    assert (!stage_full) checks++;
    else report_problem("stage_full did not fall once the channels were released");
    drain();
    end_test(4, "back-pressure", err0);

    // with B withheld AW must stop at the credit limit
    err0 = errors;
    set_holds(1'b0, 1'b1);
    repeat (40) send_update(1'b1);
    waited = 0;
    while ((aw_seen - b_seen) < `HBM_MAX_OUTSTANDING && waited < WAIT_LIMIT) begin
      @(posedge aclk);
      #1;
      waited++;
    end
    repeat (20) @(posedge aclk);
    #1;
    assert ((aw_seen - b_seen) == `HBM_MAX_OUTSTANDING) checks++;
    else report_mismatch("outstanding", aw_seen - b_seen, `HBM_MAX_OUTSTANDING);
    assert (exp_addr_q.size() == 40 - `HBM_MAX_OUTSTANDING) checks++;
    else report_mismatch("aw pending", exp_addr_q.size(), 40 - `HBM_MAX_OUTSTANDING);
    set_holds(1'b0, 1'b0);
    drain();
    end_test(5, "credit limit", err0);

    $display("tests=%0d checks passed=%0d errors=%0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
hbm_wr_pkg.sv
hbm_stage_fifo.sv
hbm_update_ingress.sv
hbm_write_issuer.sv
hbm_wr_top.sv
hbm_wr_props.sv
tb_hbm_wr_top.sv
